// File: spi_master.f
verilog/spi_pkg.sv
verilog/spi_cmd_if.sv
verilog/spi_cmd_fifo.sv
verilog/spi_shifter.sv
verilog/spi_bus_monitor.sv
verilog/spi_master_top.sv
dv/spi_slave_model.sv
dv/tb_spi_master.sv

// File: Makefile
# Verilator build and run of the spi master testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_master
FILELIST  ?= spi_master.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run $(TOP) with $(VERILATOR)"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_spi_master.sv
// ------------------------------------------------------------
// spi master testbench
// random host writes, four slave models, queue reference model
// ------------------------------------------------------------
module tb_spi_master import spi_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 16;
  // write phase length, one write chance in WR_GAP cycles
  localparam int NUM_CYCLES = 3000;
  localparam int WR_GAP     = 24;
  // quiet bus at the end, one transfer long
  localparam int TAIL_CYCLES = (2 * DATA_W + 4) * CLK_DIV;
  // reset, write phase, then a full fifo plus one in flight, one spare
  localparam longint WATCHDOG_T = longint'(RST_CYCLES + NUM_CYCLES +
    (FIFO_DEPTH + 2) * (2 * DATA_W + 4) * CLK_DIV) * CLK_PERIOD;

  logic                  sclk;
  logic                  rst_n;
  logic                  wr_en;
  logic [DATA_W-1:0]     wr_data;
  logic [SS_W-1:0]       wr_ss;
  logic                  wr_cpol;
  logic                  wr_cpha;
  logic                  full;
  logic                  busy;
  logic                  rx_valid;
  logic [DATA_W-1:0]     rx_data;
  logic [SS_W-1:0]       rx_ss;
  logic                  protocol_err;
  logic                  spi_clk;
  logic [NUM_SLAVES-1:0] cs_n;
  logic                  mosi;
  logic                  miso;

  // slave side
  logic [NUM_SLAVES-1:0]             miso_s;
  logic [NUM_SLAVES-1:0][DATA_W-1:0] next_byte;
  logic [NUM_SLAVES-1:0][DATA_W-1:0] sent_byte;
  logic [NUM_SLAVES-1:0][DATA_W-1:0] rcvd_byte;
  logic                              mode_cpol;
  logic                              mode_cpha;

  // reference model, accepted commands in order
  spi_cmd_t   exp_q[$];
  int         dropped;
  logic [3:0] modes_seen;

  initial begin
    sclk = 1'b0;
    forever #(CLK_PERIOD / 2) sclk = ~sclk;
  end

  spi_master_top dut_i (
    .sclk         (sclk),
    .rst_n        (rst_n),
    .wr_en        (wr_en),
    .wr_data      (wr_data),
    .wr_ss        (wr_ss),
    .wr_cpol      (wr_cpol),
    .wr_cpha      (wr_cpha),
    .full         (full),
    .busy         (busy),
    .rx_valid     (rx_valid),
    .rx_data      (rx_data),
    .rx_ss        (rx_ss),
    .protocol_err (protocol_err),
    .spi_clk      (spi_clk),
    .cs_n         (cs_n),
    .mosi         (mosi),
    .miso         (miso)
  );

  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slave
    spi_slave_model slave_i (
      .sclk      (sclk),
      .rst_n     (rst_n),
      .spi_clk   (spi_clk),
      .cs_n      (cs_n[i]),
      .mosi      (mosi),
      .cpol      (mode_cpol),
      .cpha      (mode_cpha),
      .tx_byte   (next_byte[i]),
      .miso      (miso_s[i]),
      .sent_byte (sent_byte[i]),
      .rcvd_byte (rcvd_byte[i])
    );
  end

  assign miso = |miso_s;

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp_val);
    assert (got == exp_val) else begin
      fail_run($sformatf("ERR %0t %s got 0x%0h expected 0x%0h",
                         $time, name, got, exp_val));
    end
  endtask

  // per cycle checks on stable outputs, retires commands on rx_valid
  task automatic watch_outputs();
    spi_cmd_t head;
    check_value("protocol_err", 32'(protocol_err), 32'(0));
    assert ($onehot0(~cs_n)) else fail_run("more than one chip select is low at once");
    if (exp_q.size() == 0) begin
      check_value("cs_n", 32'(cs_n), 32'({NUM_SLAVES{1'b1}}));
      check_value("busy", 32'(busy), 32'(0));
      // clock parked at the last command's idle level
      check_value("spi_clk", 32'(spi_clk), 32'(mode_cpol));
    end
    if (rx_valid) begin
      assert (exp_q.size() != 0) else fail_run("rx_valid with no command outstanding");
      head = exp_q.pop_front();
      modes_seen[{head.cpol, head.cpha}] = 1'b1;
      check_value("rx_ss", 32'(rx_ss), 32'(head.ss));
      check_value("rx_data", 32'(rx_data), 32'(sent_byte[head.ss]));
      check_value("slave mosi byte", 32'(rcvd_byte[head.ss]), 32'(head.data));
      // fresh byte for this slave's next select
      next_byte[head.ss] = DATA_W'($urandom);
    end
    // one command sits in the shifter except on the strobe cycle
    check_value("full", 32'(full),
                32'(exp_q.size() == (rx_valid ? FIFO_DEPTH : FIFO_DEPTH + 1)));
  endtask

  // one random write chance, dropped on full like the fifo
  task automatic drive_write();
    logic [31:0] rnd;
    spi_cmd_t    cmd;
    rnd     = $urandom;
    cmd     = rnd[$bits(spi_cmd_t)-1:0];
    wr_en   = (($urandom % WR_GAP) == 0);
    wr_data = cmd.data;
    wr_ss   = cmd.ss;
    wr_cpol = cmd.cpol;
    wr_cpha = cmd.cpha;
    if (wr_en) begin
      if (full) begin
        dropped++;
      end else begin
        exp_q.push_back(cmd);
      end
    end
  endtask

  // slaves follow the mode of the command in flight or next up
  task automatic follow_head_mode();
    if (exp_q.size() != 0) begin
      mode_cpol = exp_q[0].cpol;
      mode_cpha = exp_q[0].cpha;
    end
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(81));
    rst_n      = 1'b0;
    wr_en      = 1'b0;
    wr_data    = '0;
    wr_ss      = '0;
    wr_cpol    = 1'b0;
    wr_cpha    = 1'b0;
    mode_cpol  = 1'b0;
    mode_cpha  = 1'b0;
    dropped    = 0;
    modes_seen = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      next_byte[i] = DATA_W'($urandom);
    end
    // selects parked and no strobe while in reset
    repeat (RST_CYCLES) begin
      @(negedge sclk);
      check_value("cs_n", 32'(cs_n), 32'({NUM_SLAVES{1'b1}}));
      check_value("rx_valid", 32'(rx_valid), 32'(0));
      check_value("spi_clk", 32'(spi_clk), 32'(0));
      check_value("mosi", 32'(mosi), 32'(0));
    end
    rst_n = 1'b1;
    for (int c = 0; c < NUM_CYCLES; c++) begin
      @(negedge sclk);
      watch_outputs();
      drive_write();
      follow_head_mode();
    end
    // drain what is still queued
    while (exp_q.size() != 0) begin
      @(negedge sclk);
      wr_en = 1'b0;
      watch_outputs();
      follow_head_mode();
    end
    // no strobe may follow the last accepted command
    repeat (TAIL_CYCLES) begin
      @(negedge sclk);
      watch_outputs();
    end
    assert (dropped > 0) else fail_run("no write ever met a full FIFO");
    assert (modes_seen == 4'hf) else fail_run("not every cpol and cpha combination ran");
    $display("Finished with no errors");
    $finish;
  end

  // hang guard
  initial begin
    #(WATCHDOG_T);
    fail_run($sformatf("watchdog expired at %0t with %0d commands outstanding",
                       $time, exp_q.size()));
  end

endmodule

// File: dv/spi_slave_model.sv
// ------------------------------------------------------------
// behavioral spi slave
// shifts out a given byte while selected, collects mosi
// ------------------------------------------------------------
module spi_slave_model import spi_pkg::*; (
  input  logic              sclk,
  input  logic              rst_n,
  input  logic              spi_clk,
  input  logic              cs_n,
  input  logic              mosi,
  input  logic              cpol,
  input  logic              cpha,
  input  logic [DATA_W-1:0] tx_byte,
  output logic              miso,
  output logic [DATA_W-1:0] sent_byte,
  output logic [DATA_W-1:0] rcvd_byte
);

  logic [DATA_W-1:0] tx_sreg;
  logic              clk_q;
  logic              sel_q;
  // first leading edge only presents the MSB in mode cpha 1
  logic              lead_seen;
  logic              clk_edge;
  logic              leading;

  // edges seen one system clock late, park moves at select ignored
  assign clk_edge = !cs_n && sel_q && (spi_clk != clk_q);
  assign leading  = (spi_clk != cpol);
  // quiet unless selected, the bus is a wired OR
  assign miso     = !cs_n && tx_sreg[DATA_W-1];

  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      tx_sreg   <= '0;
      clk_q     <= 1'b0;
      sel_q     <= 1'b0;
      lead_seen <= 1'b0;
      sent_byte <= '0;
      rcvd_byte <= '0;
    end else begin
      clk_q <= spi_clk;
      sel_q <= !cs_n;
      if (!cs_n && !sel_q) begin
        // select just arrived, MSB goes out now
        tx_sreg   <= tx_byte;
        sent_byte <= tx_byte;
        lead_seen <= 1'b0;
      end else if (clk_edge) begin
        if (leading) begin
          lead_seen <= 1'b1;
        end
        // cpha 0 samples on leading, cpha 1 on trailing
        if (leading ^ cpha) begin
          rcvd_byte <= {rcvd_byte[DATA_W-2:0], mosi};
        end else if (!cpha || lead_seen) begin
          tx_sreg <= {tx_sreg[DATA_W-2:0], 1'b0};
        end
      end
    end
  end

endmodule

// File: verilog/spi_master_top.sv
// ------------------------------------------------------------
// spi master top level
// host strobes into the command FIFO, shifter drives the bus,
// monitor flags protocol errors
// ------------------------------------------------------------
module spi_master_top import spi_pkg::*; (
  input  logic                  sclk,
  input  logic                  rst_n,
  // host write side
  input  logic                  wr_en,
  input  logic [DATA_W-1:0]     wr_data,
  input  logic [SS_W-1:0]       wr_ss,
  input  logic                  wr_cpol,
  input  logic                  wr_cpha,
  // host status and return
  output logic                  full,
  output logic                  busy,
  output logic                  rx_valid,
  output logic [DATA_W-1:0]     rx_data,
  output logic [SS_W-1:0]       rx_ss,
  output logic                  protocol_err,
  // spi pins
  output logic                  spi_clk,
  output logic [NUM_SLAVES-1:0] cs_n,
  output logic                  mosi,
  input  logic                  miso
);

  spi_cmd_t wr_cmd;
  logic     active;
  logic     cur_cpol;
  logic     cur_cpha;

  spi_cmd_if cmd_if ();

  // pack the host fields
  assign wr_cmd.data = wr_data;
  assign wr_cmd.ss   = wr_ss;
  assign wr_cmd.cpol = wr_cpol;
  assign wr_cmd.cpha = wr_cpha;

  spi_cmd_fifo fifo_i (
    .sclk   (sclk),
    .rst_n  (rst_n),
    .wr_en  (wr_en),
    .wr_cmd (wr_cmd),
    .full   (full),
    .cmd_if (cmd_if.fifo)
  );

  spi_shifter shifter_i (
    .sclk     (sclk),
    .rst_n    (rst_n),
    .cmd_if   (cmd_if.shifter),
    .spi_clk  (spi_clk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso),
    .busy     (busy),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .rx_ss    (rx_ss),
    .active   (active),
    .cpol     (cur_cpol),
    .cpha     (cur_cpha)
  );

  // mode bits come from the command in flight
  spi_bus_monitor monitor_i (
    .sclk         (sclk),
    .rst_n        (rst_n),
    .spi_clk      (spi_clk),
    .cs_n         (cs_n),
    .mosi         (mosi),
    .active       (active),
    .cpol         (cur_cpol),
    .cpha         (cur_cpha),
    .protocol_err (protocol_err)
  );

endmodule

// File: verilog/spi_bus_monitor.sv
// ------------------------------------------------------------
// spi bus protocol checker
// watches selects, spi_clk and mosi, sticky error flag
// ------------------------------------------------------------
module spi_bus_monitor import spi_pkg::*; (
  input  logic                  sclk,
  input  logic                  rst_n,
  input  logic                  spi_clk,
  input  logic [NUM_SLAVES-1:0] cs_n,
  input  logic                  mosi,
  input  logic                  active,
  input  logic                  cpol,
  input  logic                  cpha,
  output logic                  protocol_err
);

  // previous pin values
  logic spi_clk_q;
  logic mosi_q;
  logic sel_q;

  logic sel;
  logic clk_edge;
  logic sample_edge;
  logic cs_viol;
  logic idle_viol;
  logic mosi_viol;

  // ------------------------------------------------------------
  // edge detect
  // ------------------------------------------------------------
  assign sel         = !(&cs_n);
  // only edges inside a selection count
  assign clk_edge    = sel && sel_q && (spi_clk != spi_clk_q);
  // leading edge leaves cpol, slave samples there when cpha is 0
  assign sample_edge = clk_edge && ((spi_clk != cpol) ^ cpha);

  // ------------------------------------------------------------
  // rules
  // ------------------------------------------------------------
  assign cs_viol   = sel && !active;
  assign idle_viol = !sel && (spi_clk != cpol);
  assign mosi_viol = sample_edge && (mosi != mosi_q);

  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      spi_clk_q    <= 1'b0;
      mosi_q       <= 1'b0;
      sel_q        <= 1'b0;
      protocol_err <= 1'b0;
    end else begin
      spi_clk_q <= spi_clk;
      mosi_q    <= mosi;
      sel_q     <= sel;
      // held until reset
      if (cs_viol || idle_viol || mosi_viol) begin
        protocol_err <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // assertions on the pins
  // ------------------------------------------------------------
  a_select_in_xfer: assert property (
    @(posedge sclk) disable iff (!rst_n)
    !active |-> &cs_n
  );

  a_idle_level: assert property (
    @(posedge sclk) disable iff (!rst_n)
    &cs_n |-> (spi_clk == cpol)
  );

  a_mosi_stable: assert property (
    @(posedge sclk) disable iff (!rst_n)
    (!(&cs_n) && !(&$past(cs_n)) && $changed(spi_clk) &&
     ((spi_clk != cpol) ^ cpha)) |-> $stable(mosi)
  );

endmodule

// File: verilog/spi_shifter.sv
// ------------------------------------------------------------
// spi serial engine
// one command at a time: chip select, spi_clk, mosi out,
// miso in MSB first, received byte back with a strobe
// ------------------------------------------------------------
module spi_shifter import spi_pkg::*; (
  input  logic                  sclk,
  input  logic                  rst_n,
  spi_cmd_if.shifter            cmd_if,
  output logic                  spi_clk,
  output logic [NUM_SLAVES-1:0] cs_n,
  output logic                  mosi,
  input  logic                  miso,
  output logic                  busy,
  output logic                  rx_valid,
  output logic [DATA_W-1:0]     rx_data,
  output logic [SS_W-1:0]       rx_ss,
  output logic                  active,
  output logic                  cpol,
  output logic                  cpha
);

  shift_state_t      state;
  // latched command, frees the fifo head during a transfer
  spi_cmd_t          cur_cmd;

  logic [DIV_W-1:0]  div_cnt;
  logic [EDGE_W-1:0] edge_cnt;
  logic [EDGE_W-1:0] edge_idx;
  logic [DATA_W-1:0] tx_sreg;
  logic [DATA_W-1:0] rx_sreg;

  logic              half_done;
  logic              last_edge;
  logic              edge_fire;
  logic              leading;
  logic              do_sample;
  logic              do_shift;

  // ------------------------------------------------------------
  // edge scheduling
  // ------------------------------------------------------------
  assign half_done = (div_cnt == DIV_W'(CLK_DIV - 1));
  assign last_edge = (edge_cnt == EDGE_W'(NUM_EDGES - 1));

  // edge 0 closes SETUP, the rest open each SHIFT half period
  assign edge_fire = half_done &&
                     ((state == SETUP) || ((state == SHIFT) && !last_edge));
  assign edge_idx  = (state == SETUP) ? '0 : edge_cnt + 1'b1;
  // even edges move away from the idle level
  assign leading   = !edge_idx[0];

  // cpha 0: sample on leading, change on trailing
  // cpha 1: the other way round, MSB is already out before edge 0
  assign do_sample = edge_fire && (cur_cmd.cpha ? !leading : leading);
  assign do_shift  = edge_fire &&
                     (cur_cmd.cpha ? (leading && (edge_idx != '0)) : !leading);

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign cmd_if.pop = (state == IDLE) && !cmd_if.empty;
  assign busy       = (state != IDLE);
  assign active     = (state != IDLE);
  // mosi parks low between transfers
  assign mosi       = busy && tx_sreg[DATA_W-1];
  assign cpol       = cur_cmd.cpol;
  assign cpha       = cur_cmd.cpha;

  // ------------------------------------------------------------
  // control FSM
  // ------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      state    <= IDLE;
      cur_cmd  <= '0;
      div_cnt  <= '0;
      edge_cnt <= '0;
      spi_clk  <= 1'b0;
      cs_n     <= '1;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      // half period divider, free running outside IDLE
      if (state != IDLE) begin
        div_cnt <= half_done ? '0 : div_cnt + 1'b1;
      end
      if (edge_fire) begin
        spi_clk <= ~spi_clk;
      end
      unique case (state)
        IDLE: begin
          if (cmd_if.pop) begin
            cur_cmd <= cmd_if.cmd;
            // park at the new idle level together with the select
            spi_clk <= cmd_if.cmd.cpol;
            cs_n    <= ~(NUM_SLAVES'(1) << cmd_if.cmd.ss);
            div_cnt <= '0;
            state   <= SETUP;
          end
        end
        SETUP: begin
          if (half_done) begin
            edge_cnt <= '0;
            state    <= SHIFT;
          end
        end
        SHIFT: begin
          if (half_done) begin
            if (last_edge) begin
              state <= HOLD;
            end else begin
              edge_cnt <= edge_idx;
            end
          end
        end
        HOLD: begin
          if (half_done) begin
            cs_n     <= '1;
            rx_valid <= 1'b1;
            state    <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // data path
  // ------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (cmd_if.pop) begin
      tx_sreg <= cmd_if.cmd.data;
    end else if (do_shift) begin
      tx_sreg <= {tx_sreg[DATA_W-2:0], 1'b0};
    end
    if (do_sample) begin
      rx_sreg <= {rx_sreg[DATA_W-2:0], miso};
    end
    // result goes out with the strobe
    if ((state == HOLD) && half_done) begin
      rx_data <= rx_sreg;
      rx_ss   <= cur_cmd.ss;
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  a_one_select: assert property (
    @(posedge sclk) disable iff (!rst_n)
    $onehot0(~cs_n)
  );

  // pull only with every select released and an entry really there
  a_pop_in_idle: assert property (
    @(posedge sclk) disable iff (!rst_n)
    cmd_if.pop |-> (&cs_n) && (cmd_if.count != '0)
  );

  // select drops the cycle after pop, strobe a full transfer later
  a_fixed_latency: assert property (
    @(posedge sclk) disable iff (!rst_n)
    cmd_if.pop |=> ##(XFER_CYCLES) rx_valid
  );

endmodule

// File: verilog/spi_cmd_fifo.sv
// ------------------------------------------------------------
// command FIFO
// circular buffer between host strobes and the shifter,
// writes while full are dropped
// ------------------------------------------------------------
module spi_cmd_fifo import spi_pkg::*; (
  input  logic       sclk,
  input  logic       rst_n,
  input  logic       wr_en,
  input  spi_cmd_t   wr_cmd,
  output logic       full,
  spi_cmd_if.fifo    cmd_if
);

  // storage, payload only
  spi_cmd_t         mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;
  logic             empty;

  // ------------------------------------------------------------
  // flags
  // ------------------------------------------------------------
  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);

  // dropped when full, even on a pop cycle
  assign push  = wr_en && !full;
  // guard against a stray pop on empty
  assign pop   = cmd_if.pop && !empty;

  assign cmd_if.empty = empty;
  assign cmd_if.count = count;
  // head entry straight from the array
  assign cmd_if.cmd   = mem[rd_ptr];

  // ------------------------------------------------------------
  // storage write
  // ------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (push) begin
      mem[wr_ptr] <= wr_cmd;
    end
  end

  // ------------------------------------------------------------
  // pointers and count
  // ------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // depth is a power of two, pointers wrap by themselves
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      unique case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  // level never runs past the array
  a_count_bound: assert property (
    @(posedge sclk) disable iff (!rst_n)
    count <= CNT_W'(FIFO_DEPTH)
  );

  // the shifter only pulls a command that is there
  a_no_pop_empty: assert property (
    @(posedge sclk) disable iff (!rst_n)
    cmd_if.pop |-> !empty
  );

endmodule

// File: verilog/spi_cmd_if.sv
// ------------------------------------------------------------
// command path between the command FIFO and the shifter
// head entry and level flags out, pop strobe back
// ------------------------------------------------------------
interface spi_cmd_if import spi_pkg::*; ();

  // head entry, valid while empty is low
  spi_cmd_t         cmd;
  logic             empty;
  // fill level
  logic [CNT_W-1:0] count;
  // one-cycle strobe, removes the head
  logic             pop;

  modport fifo (
    output cmd,
    output empty,
    output count,
    input  pop
  );

  modport shifter (
    input  cmd,
    input  empty,
    input  count,
    output pop
  );

endinterface

// File: verilog/spi_pkg.sv
// ------------------------------------------------------------
// spi master shared definitions
// sizes, serial clock divider, command layout, shifter states
// ------------------------------------------------------------
package spi_pkg;

  // transfer and bus sizes
  localparam int DATA_W     = 8;
  localparam int NUM_SLAVES = 4;
  localparam int SS_W       = 2;

  // command buffer
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

  // system clocks per spi_clk half period
  localparam int CLK_DIV    = 4;
  localparam int DIV_W      = $clog2(CLK_DIV);

  // two edges per bit
  localparam int NUM_EDGES  = 2 * DATA_W;
  localparam int EDGE_W     = $clog2(NUM_EDGES);

  // setup + shift + hold, in system clocks
  localparam int XFER_CYCLES = (NUM_EDGES + 2) * CLK_DIV;

  // one queued transfer
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [SS_W-1:0]   ss;
    logic              cpol;
    logic              cpha;
  } spi_cmd_t;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    SHIFT,
    HOLD
  } shift_state_t;

endpackage
